//--- capture_ctrl/capture_ctrl.sv
module capture_ctrl
    import img_pkg::*;
#(
    parameter int HEADER_WORDS = 8,
    parameter int BUF_DEPTH    = 1024
) (
    input  logic                              clk,
    input  logic                              fifoIn_rst,
    // Command
    input  logic                              cmd_capture,
    input  logic [HEADER_WORDS*WORD_BITS-1:0] cmd_header,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]    cmd_pixel_count,
    // Pixel side
    output logic                              arm,
    input  logic                              frame_done,
    input  logic                              pix_not_empty,
    output logic                              pix_pop,
    input  pixel_t                            pix_data,
    // Frame buffer
    output logic                              wr_en,
    output logic [$clog2(BUF_DEPTH)-1:0]      wr_addr,
    output buf_word_t                         wr_data,
    output logic                              rd_en,
    output logic [$clog2(BUF_DEPTH)-1:0]      rd_addr,
    input  buf_word_t                         rd_data,
    // Output FIFO
    output logic                              out_push,
    output buf_word_t                         out_data,
    input  logic                              out_full,
    output logic                              capture_done
);
    localparam int ADDR_BITS = $clog2(BUF_DEPTH);
    localparam int CNT_BITS  = $clog2(BUF_DEPTH + 1);
    localparam int HDR_BITS  = HEADER_WORDS * WORD_BITS;
    localparam int HCNT_BITS = $clog2(HEADER_WORDS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_CAPTURE,
        ST_READOUT
    } state_t;

    state_t               state;
    logic [HDR_BITS-1:0]  header_q;
    logic [HCNT_BITS-1:0] hdr_cnt;
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0]  rd_left;
    logic                 frame_seen;
    logic                 rd_valid;
    logic                 capture_end;
    logic                 rd_issue;

    // Input FIFO drains one word per cycle
    assign pix_pop     = pix_not_empty;
    assign capture_end = (frame_seen || frame_done) && !pix_not_empty;

    // Only issue with nothing in flight, so out_full is exact and a slot is free
    assign rd_issue = (state == ST_READOUT) && (rd_left != '0) && !out_full &&
                      !rd_en && !rd_valid;

    // Buffer read data lands one cycle after the strobe
    assign out_push = rd_valid;
    assign out_data = rd_data;

    // ==============================
    // Job sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state        <= ST_IDLE;
            hdr_cnt      <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            rd_left      <= '0;
            frame_seen   <= 1'b0;
            rd_valid     <= 1'b0;
            arm          <= 1'b0;
            capture_done <= 1'b0;
            wr_en        <= 1'b0;
            rd_en        <= 1'b0;
        end else begin
            arm          <= 1'b0;
            capture_done <= 1'b0;
            wr_en        <= 1'b0;
            rd_en        <= rd_issue;
            rd_valid     <= rd_en;
            case (state)
                ST_IDLE: begin
                    if (cmd_capture) begin
                        hdr_cnt <= '0;
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        rd_left <= cmd_pixel_count;
                        state   <= ST_HEADER;
                    end
                end
                // One header word per cycle, then arm the input side
                ST_HEADER: begin
                    if (hdr_cnt == HCNT_BITS'(HEADER_WORDS)) begin
                        arm        <= 1'b1;
                        frame_seen <= 1'b0;
                        state      <= ST_CAPTURE;
                    end else begin
                        wr_en   <= 1'b1;
                        hdr_cnt <= hdr_cnt + 1'b1;
                        wr_ptr  <= wr_ptr + 1'b1;
                    end
                end
                ST_CAPTURE: begin
                    if (frame_done) begin
                        frame_seen <= 1'b1;
                    end
                    if (pix_not_empty) begin
                        wr_en  <= 1'b1;
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (capture_end) begin
                        capture_done <= 1'b1;
                        state        <= ST_READOUT;
                    end
                end
                ST_READOUT: begin
                    if (rd_issue) begin
                        rd_ptr  <= rd_ptr + 1'b1;
                        rd_left <= rd_left - 1'b1;
                    end else if ((rd_left == '0) && !rd_en && !rd_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==============================
    // Write and read payload
    // ==============================
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && cmd_capture) begin
            header_q <= cmd_header;
        end else if (state == ST_HEADER) begin
            header_q <= header_q << WORD_BITS;
        end
        wr_addr <= wr_ptr;
        // Most significant header word goes first
        if (state == ST_HEADER) begin
            wr_data <= header_q[HDR_BITS-1 -: WORD_BITS];
        end else begin
            wr_data <= {{(WORD_BITS - PIXEL_BITS){1'b0}}, pix_data};
        end
        rd_addr <= rd_ptr;
    end

endmodule

//--- common/img_pkg.sv
package img_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int PIXEL_BITS    = 12;
    localparam int WORD_BITS     = 16;
    // Enough for a 256 pixel side
    localparam int DIM_BITS      = 9;
    localparam int STAT_BITS     = 18;
    // High pixel bits that decide highlight or shadow
    localparam int STAT_TOP_BITS = 7;

    // ==============================
    // Types
    // ==============================
    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic [WORD_BITS-1:0]  buf_word_t;
    typedef logic [DIM_BITS-1:0]   dim_t;
    typedef logic [STAT_BITS-1:0]  stat_t;

    // Camera port, sampled on every clock
    typedef struct packed {
        logic   fv;
        logic   lv;
        pixel_t d;
    } pix_in_t;

    // Result of one captured frame
    typedef struct packed {
        dim_t  width;
        dim_t  height;
        stat_t highlight_count;
        stat_t shadow_count;
    } cap_status_t;

endpackage

//--- img_controller.f
common/img_pkg.sv
verilog/word_fifo.sv
verilog/frame_buffer.sv
pixel_capture/pixel_capture.sv
capture_ctrl/capture_ctrl.sv
verilog/img_controller.sv
verification/img_controller_tb.sv

//--- pixel_capture/pixel_capture.sv
module pixel_capture
    import img_pkg::*;
(
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        arm,
    input  pix_in_t     img,
    output logic        push,
    output pixel_t      pixel,
    output logic        frame_done,
    output cap_status_t status
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_LOW,
        ST_WAIT_HIGH,
        ST_CAPTURE
    } state_t;

    state_t                   state;
    logic                     lv_prev;
    logic [1:0]               col;
    logic [1:0]               row;
    logic                     take;
    logic                     on_grid;
    logic [STAT_TOP_BITS-1:0] top_bits;

    // The frame starts on the first cycle fv is seen high after the low phase
    assign take     = img.fv && img.lv &&
                      ((state == ST_WAIT_HIGH) || (state == ST_CAPTURE));
    assign on_grid  = (col == 2'd0) && (row == 2'd0);
    assign top_bits = img.d[PIXEL_BITS-1 -: STAT_TOP_BITS];

    // ==============================
    // Frame sync
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state      <= ST_IDLE;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (arm) begin
                state <= ST_WAIT_LOW;
            end else begin
                case (state)
                    // Skip any frame already in progress
                    ST_WAIT_LOW: begin
                        if (!img.fv) begin
                            state <= ST_WAIT_HIGH;
                        end
                    end
                    ST_WAIT_HIGH: begin
                        if (img.fv) begin
                            state <= ST_CAPTURE;
                        end
                    end
                    ST_CAPTURE: begin
                        if (!img.fv) begin
                            frame_done <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Push register toward the pixel FIFO
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            push <= 1'b0;
        end else begin
            push <= take;
        end
    end

    always_ff @(posedge clk) begin
        pixel <= img.d;
    end

    // ==============================
    // Line position
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            lv_prev <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            lv_prev <= img.lv;
            if (!img.lv) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
            // Row advances at the end of each line
            if (!img.fv) begin
                row <= '0;
            end else if (lv_prev && !img.lv) begin
                row <= row + 1'b1;
            end
        end
    end

    // ==============================
    // Dimensions and statistics
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || arm) begin
            status <= '0;
        end else if (take) begin
            if (!lv_prev) begin
                status.width  <= DIM_BITS'(1);
                status.height <= status.height + 1'b1;
            end else begin
                status.width <= status.width + 1'b1;
            end
            if (on_grid && (&top_bits)) begin
                status.highlight_count <= status.highlight_count + 1'b1;
            end
            if (on_grid && !(|top_bits)) begin
                status.shadow_count <= status.shadow_count + 1'b1;
            end
        end
    end

endmodule

//--- verification/img_controller_stim.txt
// Record count, then one record per test, all values in hex
// Record: 8 header words (first one written first), then
//   lines, pixels per line, idle gap, fv high at arm, pixel salt,
//   readout words, trigger spacing, expected width, expected height
5

// Small frame, triggers back to back
CAFE 0001 0002 0003 0004 0005 0006 BEEF
5 9 3 0 000 35 1 9 5

// Frame already running when armed, output FIFO fills
1234 5678 9ABC DEF0 0F0F F0F0 AAAA 5555
8 10 2 1 A5A 88 4 10 8

// Partial readout with slow triggers
FFFF 0000 8000 0001 7FFF FFFE 00FF FF00
3 6 5 0 3C3 14 C 6 3

// One cycle gap between lines
A001 A002 A003 A004 A005 A006 A007 A008
C 14 1 1 0F0 F8 2 14 C

// Wide lines with inverted random pixels
0BAD F00D 1111 2222 3333 4444 5555 6666
4 28 2 0 FFF A8 6 28 4

//--- verification/img_controller_tb.sv
module img_controller_tb
    import img_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          HEADER_WORDS = 8;
    localparam int          BUF_DEPTH    = 1024;
    localparam int          FIFO_DEPTH   = 8;
    localparam int          CNT_BITS     = $clog2(BUF_DEPTH + 1);
    localparam int          REC_WORDS    = HEADER_WORDS + 9;
    localparam int          TIMEOUT      = 2000;
    localparam int          QUIET_CYCLES = 20;
    localparam logic [31:0] RAND_SEED    = 32'h9130_7f95;

    logic                              clk;
    logic                              fifoIn_rst;
    logic                              cmd_capture;
    logic [HEADER_WORDS*WORD_BITS-1:0] cmd_header;
    logic [CNT_BITS-1:0]               cmd_pixel_count;
    pix_in_t                           img;
    logic                              readout_ready;
    logic                              readout_trigger;
    buf_word_t                         readout_data;
    logic                              status_capture_done;
    cap_status_t                       status;

    logic [31:0] stim_mem [0:255];
    // Expected buffer contents of the current job
    buf_word_t   model [$];
    int          exp_high;
    int          exp_shadow;
    int          errors;
    int          checks;

    img_controller #(
        .HEADER_WORDS (HEADER_WORDS),
        .BUF_DEPTH    (BUF_DEPTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) img_controller_inst (
        .clk                 (clk),
        .fifoIn_rst          (fifoIn_rst),
        .cmd_capture         (cmd_capture),
        .cmd_header          (cmd_header),
        .cmd_pixel_count     (cmd_pixel_count),
        .img                 (img),
        .readout_ready       (readout_ready),
        .readout_trigger     (readout_trigger),
        .readout_data        (readout_data),
        .status_capture_done (status_capture_done),
        .status              (status)
    );

    always #5 clk = ~clk;

    // ==============================
    // Checks and stimulus helpers
    // ==============================
    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            img = '0;
        end
    endtask

    // Grid points get forced extremes now and then so the counters move
    task automatic make_pixel(input pixel_t salt, input logic on_grid, output pixel_t value);
        int unsigned pick;
        pick  = $urandom % 4;
        value = pixel_t'($urandom) ^ salt;
        if (on_grid && (pick == 0)) begin
            value = 12'hFFF;
        end else if (on_grid && (pick == 1)) begin
            value = 12'h000;
        end
    endtask

    // A frame already running at arm time must not reach the buffer
    task automatic drive_pre_frame(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            img.fv = 1'b1;
            img.lv = i[1];
            img.d  = pixel_t'($urandom);
        end
    endtask

    task automatic drive_frame(input int lines, input int ppl, input int gap,
                               input pixel_t salt);
        pixel_t value;
        pixel_t top;
        logic   on_grid;
        for (int r = 0; r <= lines; r++) begin
            drive_gap(gap);
            for (int c = 0; c < ppl && r < lines; c++) begin
                on_grid = ((r % 4) == 0) && ((c % 4) == 0);
                make_pixel(salt, on_grid, value);
                @(negedge clk);
                img.fv = 1'b1;
                img.lv = 1'b1;
                img.d  = value;
                model.push_back(buf_word_t'(value));
                // Top bits of the pixel moved down to the low end
                top = value >> (PIXEL_BITS - STAT_TOP_BITS);
                if (on_grid && (top == pixel_t'((1 << STAT_TOP_BITS) - 1))) begin
                    exp_high++;
                end
                if (on_grid && (top == '0)) begin
                    exp_shadow++;
                end
            end
        end
        @(negedge clk);
        img = '0;
    endtask

    task automatic drive_gap(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            img.fv = 1'b1;
            img.lv = 1'b0;
        end
    endtask

    task automatic wait_capture_done(output logic ok);
        int waited;
        ok     = 1'b0;
        waited = 0;
        while (!ok && (waited < TIMEOUT)) begin
            @(negedge clk);
            ok = status_capture_done;
            waited++;
        end
        if (!ok) begin
            report_failure("timeout, status_capture_done never pulsed after the frame");
        end
    endtask

    task automatic read_out(input int count, input int spacing, output logic ok);
        int waited;
        ok = 1'b1;
        for (int i = 0; (i < count) && ok; i++) begin
            waited = 0;
            while (!readout_ready && (waited < TIMEOUT)) begin
                @(negedge clk);
                waited++;
            end
            if (!readout_ready) begin
                report_failure($sformatf("timeout, readout word %0d never became ready", i));
                ok = 1'b0;
            end else begin
                check($sformatf("readout_data[%0d]", i), readout_data, model[i]);
                readout_trigger = 1'b1;
                @(negedge clk);
                readout_trigger = 1'b0;
                repeat (spacing - 1) @(negedge clk);
            end
        end
    endtask

    // ==============================
    // One job per record
    // ==============================
    task automatic run_record(input int base, input int index, output logic ok);
        int lines;
        int ppl;
        int gap;
        int count;
        int spacing;
        int errors_before;
        errors_before = errors;
        lines         = stim_mem[base + HEADER_WORDS];
        ppl           = stim_mem[base + HEADER_WORDS + 1];
        gap           = stim_mem[base + HEADER_WORDS + 2];
        count         = stim_mem[base + HEADER_WORDS + 5];
        spacing       = stim_mem[base + HEADER_WORDS + 6];
        exp_high      = 0;
        exp_shadow    = 0;
        model.delete();
        @(negedge clk);
        for (int w = 0; w < HEADER_WORDS; w++) begin
            model.push_back(buf_word_t'(stim_mem[base + w]));
            cmd_header[(HEADER_WORDS-1-w)*WORD_BITS +: WORD_BITS] = model[w];
        end
        cmd_pixel_count = CNT_BITS'(count);
        cmd_capture     = 1'b1;
        @(negedge clk);
        cmd_capture = 1'b0;
        if (stim_mem[base + HEADER_WORDS + 3] != 0) begin
            drive_pre_frame(HEADER_WORDS + 6);
            drive_idle(gap + 2);
        end else begin
            drive_idle(HEADER_WORDS + 6);
        end
        drive_frame(lines, ppl, gap, pixel_t'(stim_mem[base + HEADER_WORDS + 4]));
        wait_capture_done(ok);
        if (ok) begin
            check("status.width", status.width, stim_mem[base + HEADER_WORDS + 7]);
            check("status.height", status.height, stim_mem[base + HEADER_WORDS + 8]);
            check("status.highlight_count", status.highlight_count, exp_high);
            check("status.shadow_count", status.shadow_count, exp_shadow);
            read_out(count, spacing, ok);
        end
        for (int i = 0; (i < QUIET_CYCLES) && ok; i++) begin
            @(negedge clk);
            if (readout_ready) begin
                report_failure("readout offered more words than cmd_pixel_count");
                ok = 1'b0;
            end
        end
        $display("test %0d: %0d lines of %0d pixels, %0d words read, %0d errors",
                 index, lines, ppl, count, errors - errors_before);
    endtask

    initial begin
        int   records;
        logic ok;
        void'($urandom(RAND_SEED));
        clk             = 1'b0;
        fifoIn_rst      = 1'b0;
        cmd_capture     = 1'b0;
        cmd_header      = '0;
        cmd_pixel_count = '0;
        img             = '0;
        readout_trigger = 1'b0;
        errors          = 0;
        checks          = 0;
        ok              = 1'b1;
        $readmemh("verification/img_controller_stim.txt", stim_mem);
        repeat (3) @(negedge clk);
        fifoIn_rst = 1'b1;
        @(negedge clk);
        check("readout_ready", readout_ready, 1'b0);
        check("status_capture_done", status_capture_done, 1'b0);
        $display("test 0: reset values, %0d errors", errors);
        records = stim_mem[0];
        if ((^stim_mem[0] === 1'bx) || (records == 0)) begin
            report_failure("the stimulus file holds no records");
            records = 0;
        end
        for (int r = 0; (r < records) && ok; r++) begin
            run_record(1 + r * REC_WORDS, r + 1, ok);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/frame_buffer.sv
module frame_buffer
    import img_pkg::*;
#(
    parameter int BUF_DEPTH = 1024
) (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [$clog2(BUF_DEPTH)-1:0] wr_addr,
    input  buf_word_t                    wr_data,
    input  logic                         rd_en,
    input  logic [$clog2(BUF_DEPTH)-1:0] rd_addr,
    output buf_word_t                    rd_data
);
    buf_word_t mem [BUF_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read with data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- verilog/img_controller.sv
module img_controller
    import img_pkg::*;
#(
    parameter int HEADER_WORDS = 8,
    parameter int BUF_DEPTH    = 1024,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                              clk,
    input  logic                              fifoIn_rst,
    // Command port
    input  logic                              cmd_capture,
    input  logic [HEADER_WORDS*WORD_BITS-1:0] cmd_header,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]    cmd_pixel_count,
    // Camera
    input  pix_in_t                           img,
    // Readout port
    output logic                              readout_ready,
    input  logic                              readout_trigger,
    output buf_word_t                         readout_data,
    // Status
    output logic                              status_capture_done,
    output cap_status_t                       status
);
    localparam int ADDR_BITS = $clog2(BUF_DEPTH);

    logic                 arm;
    logic                 frame_done;
    logic                 pix_push;
    pixel_t               pix_in;
    logic                 pix_pop;
    pixel_t               pix_out;
    logic                 pix_not_empty;
    logic                 wr_en;
    logic [ADDR_BITS-1:0] wr_addr;
    buf_word_t            wr_data;
    logic                 rd_en;
    logic [ADDR_BITS-1:0] rd_addr;
    buf_word_t            rd_data;
    logic                 out_push;
    buf_word_t            out_data;
    logic                 out_full;

    // ==============================
    // Input side
    // ==============================
    pixel_capture pixel_capture_inst (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .arm        (arm),
        .img        (img),
        .push       (pix_push),
        .pixel      (pix_in),
        .frame_done (frame_done),
        .status     (status)
    );

    // Never fills since the controller drains it every cycle
    word_fifo #(
        .DEPTH (FIFO_DEPTH),
        .T     (pixel_t)
    ) pixel_fifo (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .push       (pix_push),
        .push_data  (pix_in),
        .pop        (pix_pop),
        .pop_data   (pix_out),
        .not_empty  (pix_not_empty),
        .full       ()
    );

    // ==============================
    // Controller and buffer
    // ==============================
    capture_ctrl #(
        .HEADER_WORDS (HEADER_WORDS),
        .BUF_DEPTH    (BUF_DEPTH)
    ) capture_ctrl_inst (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .cmd_pixel_count (cmd_pixel_count),
        .arm             (arm),
        .frame_done      (frame_done),
        .pix_not_empty   (pix_not_empty),
        .pix_pop         (pix_pop),
        .pix_data        (pix_out),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .out_push        (out_push),
        .out_data        (out_data),
        .out_full        (out_full),
        .capture_done    (status_capture_done)
    );

    frame_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) frame_buffer_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Readout port is the read side of this FIFO
    word_fifo #(
        .DEPTH (FIFO_DEPTH),
        .T     (buf_word_t)
    ) out_fifo (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .push       (out_push),
        .push_data  (out_data),
        .pop        (readout_trigger),
        .pop_data   (readout_data),
        .not_empty  (readout_ready),
        .full       (out_full)
    );

endmodule

//--- verilog/word_fifo.sv
module word_fifo #(
    parameter int  DEPTH = 8,
    parameter type T     = logic [15:0]
) (
    input  logic clk,
    input  logic fifoIn_rst,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic not_empty,
    output logic full
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // Push while full and pop while empty are dropped
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign full      = (count == CNT_BITS'(DEPTH));
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
